//--- design/matrix_consts.svh
//**************************************************************************
// matrix entry limits and timing
//**************************************************************************
`ifndef MATRIX_CONSTS_SVH
`define MATRIX_CONSTS_SVH

// accepted matrix dimensions
`define MATRIX_MAX_ROWS 5
`define MATRIX_MAX_COLS 5

// index and count widths, wide enough for the max dimension itself
`define MATRIX_ROW_IDX_W 3
`define MATRIX_COL_IDX_W 3

// signed element width
`define MATRIX_ELEM_W 8

// serial bit time in clocks, short for simulation
`define UART_CLKS_PER_BIT 8

// idle cycles before the rest of the matrix is zero padded
`define MATRIX_TIMEOUT_CYCLES 200

`endif

//--- design/matrix_pkg.sv
//**************************************************************************
// matrix entry types
//**************************************************************************
`default_nettype none

`include "matrix_consts.svh"

package matrix_pkg;

  // one stored matrix element
  typedef logic signed [`MATRIX_ELEM_W-1:0] elem_t;

  // received byte, read either as a character or as a raw element
  typedef union packed {
    // character code for the digit test
    logic [7:0]        chr;
    // signed value when the byte is not a digit
    logic signed [7:0] raw;
  } rx_byte_u;

endpackage

`default_nettype wire

//--- design/uart_rx.sv
//**************************************************************************
// uart receiver, 8N1
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "matrix_consts.svh"

module uart_rx #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rxd,
  output logic [7:0] rx_data,
  output logic       rx_done
);

  localparam int CNT_W = $clog2(clks_per_bit + 1);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(clks_per_bit - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(clks_per_bit / 2 - 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t        state;
  logic             rxd_meta;
  logic             rxd_sync;
  logic             rxd_q;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift_q;
  logic             start_edge;
  logic             bit_tick;

  assign start_edge = rxd_q & ~rxd_sync;
  assign bit_tick   = (clk_cnt == BIT_LAST);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // line idles high
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_q    <= 1'b1;
      state    <= RX_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_done  <= 1'b0;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_q    <= rxd_sync;
      rx_done  <= 1'b0;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (start_edge) state <= RX_START;
        end
        RX_START: begin
          // recheck at mid start bit, glitches go back to idle
          if (clk_cnt == HALF_LAST) begin
            clk_cnt <= '0;
            state   <= rxd_sync ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_tick) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= RX_STOP;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          // stop bit must be high, else the byte is dropped
          if (bit_tick) begin
            state   <= RX_IDLE;
            rx_done <= rxd_sync;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // lsb first shift, byte held until the next good stop bit
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_tick) shift_q <= {rxd_sync, shift_q[7:1]};
    if (state == RX_STOP && bit_tick && rxd_sync) rx_data <= shift_q;
  end

endmodule

`default_nettype wire

//--- design/matrix_input.sv
//**************************************************************************
// matrix entry controller
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "matrix_consts.svh"

module matrix_input (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           start_en,
  input  wire  [7:0]                    rx_data,
  input  wire                           rx_done,
  input  wire                           exit_input,
  output logic                          err,
  output logic                          wr_cmd_new,
  output logic                          wr_cmd_single,
  output logic [`MATRIX_ROW_IDX_W-1:0]  wr_dims_r,
  output logic [`MATRIX_COL_IDX_W-1:0]  wr_dims_c,
  output logic [`MATRIX_ROW_IDX_W-1:0]  wr_row_idx,
  output logic [`MATRIX_COL_IDX_W-1:0]  wr_col_idx,
  output matrix_pkg::elem_t             wr_data,
  output logic                          input_done
);

  localparam int TIMER_W = $clog2(`MATRIX_TIMEOUT_CYCLES + 1);
  localparam logic [TIMER_W-1:0] TIMEOUT = TIMER_W'(`MATRIX_TIMEOUT_CYCLES);

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_GET_ROWS,
    ST_GET_COLS,
    ST_CREATE,
    ST_WAIT_DATA,
    ST_WRITE,
    ST_PAD_ZERO,
    ST_NEXT_ELEM,
    ST_ERROR,
    ST_DONE
  } state_t;

  state_t                       state;
  state_t                       next_state;
  logic [`MATRIX_ROW_IDX_W-1:0] cnt_r;
  logic [`MATRIX_COL_IDX_W-1:0] cnt_c;
  logic                         padding;
  logic [TIMER_W-1:0]           timer;
  logic                         timed_out;
  logic                         last_elem;
  logic                         rows_ok;
  logic                         cols_ok;
  matrix_pkg::rx_byte_u         rx_byte;
  matrix_pkg::elem_t            rx_val;

  // digits give their value, anything else is a raw signed element
  assign rx_byte = rx_data;
  always_comb begin
    if (rx_byte.chr >= 8'h30 && rx_byte.chr <= 8'h39)
      rx_val = matrix_pkg::elem_t'(rx_byte.chr - 8'h30);
    else
      rx_val = matrix_pkg::elem_t'(rx_byte.raw);
  end

  assign rows_ok   = (rx_val >= 1) && (rx_val <= `MATRIX_MAX_ROWS);
  assign cols_ok   = (rx_val >= 1) && (rx_val <= `MATRIX_MAX_COLS);
  assign timed_out = (timer == TIMEOUT);
  assign last_elem = (cnt_c == wr_dims_c - 1'b1) && (cnt_r == wr_dims_r - 1'b1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state <= ST_IDLE;
    else state <= next_state;
  end

  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE: if (start_en) next_state = ST_GET_ROWS;
      ST_GET_ROWS: begin
        if (exit_input) next_state = ST_DONE;
        else if (rx_done) next_state = rows_ok ? ST_GET_COLS : ST_ERROR;
      end
      ST_GET_COLS: if (rx_done) next_state = cols_ok ? ST_CREATE : ST_ERROR;
      ST_CREATE: next_state = ST_WAIT_DATA;
      ST_WAIT_DATA: begin
        if (rx_done) next_state = ST_WRITE;
        else if (timed_out) next_state = ST_PAD_ZERO;
      end
      ST_WRITE, ST_PAD_ZERO: next_state = ST_NEXT_ELEM;
      ST_NEXT_ELEM: begin
        // whole matrix written, ready for another
        if (last_elem) next_state = ST_GET_ROWS;
        else if (padding) next_state = ST_PAD_ZERO;
        else next_state = ST_WAIT_DATA;
      end
      ST_ERROR, ST_DONE: if (!start_en) next_state = ST_IDLE;
      default: next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err           <= 1'b0;
      input_done    <= 1'b0;
      wr_cmd_new    <= 1'b0;
      wr_cmd_single <= 1'b0;
      wr_dims_r     <= '0;
      wr_dims_c     <= '0;
      cnt_r         <= '0;
      cnt_c         <= '0;
      padding       <= 1'b0;
      timer         <= '0;
    end else begin
      wr_cmd_new    <= 1'b0;
      wr_cmd_single <= 1'b0;
      // status levels follow the state they report
      err           <= (next_state == ST_ERROR);
      input_done    <= (next_state == ST_DONE);
      // idle timer, counts only while an element is awaited
      if (state != ST_WAIT_DATA) timer <= '0;
      else if (!timed_out) timer <= timer + 1'b1;
      case (state)
        ST_IDLE: padding <= 1'b0;
        ST_GET_ROWS: begin
          if (next_state == ST_GET_COLS) wr_dims_r <= rx_val[`MATRIX_ROW_IDX_W-1:0];
        end
        ST_GET_COLS: begin
          if (next_state == ST_CREATE) wr_dims_c <= rx_val[`MATRIX_COL_IDX_W-1:0];
        end
        ST_CREATE: begin
          wr_cmd_new <= 1'b1;
          cnt_r      <= '0;
          cnt_c      <= '0;
          padding    <= 1'b0;
        end
        ST_WAIT_DATA: if (!rx_done && timed_out) padding <= 1'b1;
        ST_WRITE, ST_PAD_ZERO: wr_cmd_single <= 1'b1;
        ST_NEXT_ELEM: begin
          // row-major walk
          if (cnt_c == wr_dims_c - 1'b1) begin
            cnt_c <= '0;
            if (!last_elem) cnt_r <= cnt_r + 1'b1;
          end else begin
            cnt_c <= cnt_c + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_WRITE || state == ST_PAD_ZERO) begin
      wr_row_idx <= cnt_r;
      wr_col_idx <= cnt_c;
      wr_data    <= (state == ST_WRITE) ? rx_val : '0;
    end
  end

endmodule

`default_nettype wire

//--- design/matrix_store.sv
//**************************************************************************
// single matrix store
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "matrix_consts.svh"

module matrix_store (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           wr_cmd_new,
  input  wire                           wr_cmd_single,
  input  wire  [`MATRIX_ROW_IDX_W-1:0]  wr_dims_r,
  input  wire  [`MATRIX_COL_IDX_W-1:0]  wr_dims_c,
  input  wire  [`MATRIX_ROW_IDX_W-1:0]  wr_row_idx,
  input  wire  [`MATRIX_COL_IDX_W-1:0]  wr_col_idx,
  input  wire  matrix_pkg::elem_t       wr_data,
  input  wire  [`MATRIX_ROW_IDX_W-1:0]  rd_row,
  input  wire  [`MATRIX_COL_IDX_W-1:0]  rd_col,
  output matrix_pkg::elem_t             rd_data,
  output logic [`MATRIX_ROW_IDX_W-1:0]  dims_rows,
  output logic [`MATRIX_COL_IDX_W-1:0]  dims_cols
);

  matrix_pkg::elem_t mem [`MATRIX_MAX_ROWS][`MATRIX_MAX_COLS];

  // dimensions of the current matrix, zero means empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dims_rows <= '0;
      dims_cols <= '0;
    end else if (wr_cmd_new) begin
      dims_rows <= wr_dims_r;
      dims_cols <= wr_dims_c;
    end
  end

  // a new matrix starts all zero
  always_ff @(posedge clk) begin
    if (wr_cmd_new) begin
      for (int r = 0; r < `MATRIX_MAX_ROWS; r++) begin
        for (int c = 0; c < `MATRIX_MAX_COLS; c++) begin
          mem[r][c] <= '0;
        end
      end
    end else if (wr_cmd_single) begin
      mem[wr_row_idx][wr_col_idx] <= wr_data;
    end
  end

  // outside the current dimensions reads as zero
  always_comb begin
    if (rd_row < dims_rows && rd_col < dims_cols)
      rd_data = mem[rd_row][rd_col];
    else
      rd_data = '0;
  end

endmodule

`default_nettype wire

//--- design/matrix_entry_top.sv
//**************************************************************************
// matrix entry top level
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "matrix_consts.svh"

module matrix_entry_top (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           rxd,
  input  wire                           start_en,
  input  wire                           exit_input,
  input  wire  [`MATRIX_ROW_IDX_W-1:0]  rd_row,
  input  wire  [`MATRIX_COL_IDX_W-1:0]  rd_col,
  output matrix_pkg::elem_t             rd_data,
  output logic [`MATRIX_ROW_IDX_W-1:0]  dims_rows,
  output logic [`MATRIX_COL_IDX_W-1:0]  dims_cols,
  output logic                          err,
  output logic                          input_done
);

  logic [7:0]                   rx_data;
  logic                         rx_done;
  logic                         wr_cmd_new;
  logic                         wr_cmd_single;
  logic [`MATRIX_ROW_IDX_W-1:0] wr_dims_r;
  logic [`MATRIX_COL_IDX_W-1:0] wr_dims_c;
  logic [`MATRIX_ROW_IDX_W-1:0] wr_row_idx;
  logic [`MATRIX_COL_IDX_W-1:0] wr_col_idx;
  matrix_pkg::elem_t            wr_data;

  uart_rx #(
    .clks_per_bit(`UART_CLKS_PER_BIT)
  ) i_uart_rx (
    .clk    (clk),
    .rst_n  (rst_n),
    .rxd    (rxd),
    .rx_data(rx_data),
    .rx_done(rx_done)
  );

  matrix_input i_matrix_input (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_en     (start_en),
    .rx_data      (rx_data),
    .rx_done      (rx_done),
    .exit_input   (exit_input),
    .err          (err),
    .wr_cmd_new   (wr_cmd_new),
    .wr_cmd_single(wr_cmd_single),
    .wr_dims_r    (wr_dims_r),
    .wr_dims_c    (wr_dims_c),
    .wr_row_idx   (wr_row_idx),
    .wr_col_idx   (wr_col_idx),
    .wr_data      (wr_data),
    .input_done   (input_done)
  );

  matrix_store i_matrix_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_cmd_new   (wr_cmd_new),
    .wr_cmd_single(wr_cmd_single),
    .wr_dims_r    (wr_dims_r),
    .wr_dims_c    (wr_dims_c),
    .wr_row_idx   (wr_row_idx),
    .wr_col_idx   (wr_col_idx),
    .wr_data      (wr_data),
    .rd_row       (rd_row),
    .rd_col       (rd_col),
    .rd_data      (rd_data),
    .dims_rows    (dims_rows),
    .dims_cols    (dims_cols)
  );

endmodule

`default_nettype wire

//--- testbench/matrix_entry_properties.sv
//**************************************************************************
// matrix entry protocol assertions
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "matrix_consts.svh"

module matrix_entry_properties (
  input wire                          clk,
  input wire                          rst_n,
  input wire                          start_en,
  input wire                          err,
  input wire                          input_done,
  input wire                          wr_cmd_new,
  input wire                          wr_cmd_single,
  input wire [`MATRIX_ROW_IDX_W-1:0]  wr_row_idx,
  input wire [`MATRIX_COL_IDX_W-1:0]  wr_col_idx,
  input wire [`MATRIX_ROW_IDX_W-1:0]  dims_rows,
  input wire [`MATRIX_COL_IDX_W-1:0]  dims_cols
);

  // new and single writes never share a cycle
  cmd_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr_cmd_new && wr_cmd_single))
    else $error("new and single write commands high together");

  // at most one element write per two cycles
  single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    wr_cmd_single |=> !wr_cmd_single)
    else $error("single write command high two cycles in a row");

  // element writes stay inside the latched matrix
  index_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    wr_cmd_single |-> (wr_row_idx < dims_rows) && (wr_col_idx < dims_cols))
    else $error("element write outside the current dimensions");

  status_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(err && input_done))
    else $error("err and input_done high together");

  // status levels hold for the whole session
  err_held: assert property (@(posedge clk) disable iff (!rst_n)
    err && start_en |=> err)
    else $error("err fell while start_en was high");

  done_held: assert property (@(posedge clk) disable iff (!rst_n)
    input_done && start_en |=> input_done)
    else $error("input_done fell while start_en was high");

endmodule

`default_nettype wire

//--- testbench/matrix_entry_tb.sv
//**************************************************************************
// matrix entry testbench
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "matrix_consts.svh"

module matrix_entry_tb;

  localparam int BIT_CYCLES  = `UART_CLKS_PER_BIT;
  localparam int BYTE_CYCLES = 10 * BIT_CYCLES;
  // 24 bytes in all tests plus one padding timeout and three read sweeps of 25 cells
  localparam int RUN_CYCLES  = 24 * BYTE_CYCLES + `MATRIX_TIMEOUT_CYCLES + 3 * 25 * 2;
  localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES + 500;
  localparam int WAIT_LIMIT  = BYTE_CYCLES + `MATRIX_TIMEOUT_CYCLES + 100;

  logic                         clk;
  logic                         rst_n;
  logic                         rxd;
  logic                         start_en;
  logic                         exit_input;
  logic [`MATRIX_ROW_IDX_W-1:0] rd_row;
  logic [`MATRIX_COL_IDX_W-1:0] rd_col;
  matrix_pkg::elem_t            rd_data;
  logic [`MATRIX_ROW_IDX_W-1:0] dims_rows;
  logic [`MATRIX_COL_IDX_W-1:0] dims_cols;
  logic                         err;
  logic                         input_done;

  logic [31:0]       lfsr_q = 32'h3b30add2;
  int                writes_seen = 0;
  int                model_rows;
  int                model_cols;
  matrix_pkg::elem_t model [`MATRIX_MAX_ROWS][`MATRIX_MAX_COLS];

  matrix_entry_top i_matrix_entry_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .rxd       (rxd),
    .start_en  (start_en),
    .exit_input(exit_input),
    .rd_row    (rd_row),
    .rd_col    (rd_col),
    .rd_data   (rd_data),
    .dims_rows (dims_rows),
    .dims_cols (dims_cols),
    .err       (err),
    .input_done(input_done)
  );

  bind matrix_entry_top matrix_entry_properties i_matrix_entry_properties (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_en     (start_en),
    .err          (err),
    .input_done   (input_done),
    .wr_cmd_new   (wr_cmd_new),
    .wr_cmd_single(wr_cmd_single),
    .wr_row_idx   (wr_row_idx),
    .wr_col_idx   (wr_col_idx),
    .dims_rows    (dims_rows),
    .dims_cols    (dims_cols)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // counts element writes at the edge that commits them to the store
  always @(posedge clk) begin
    if (i_matrix_entry_top.wr_cmd_single === 1'b1) writes_seen <= writes_seen + 1;
  end

  // fibonacci lfsr with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [7:0] random_byte();
    logic [7:0] b;
    logic       fb;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      b      = {b[6:0], fb};
    end
    return b;
  endfunction

  // an ascii digit gives its value and any other byte is a signed element
  function automatic matrix_pkg::elem_t decode_byte(input logic [7:0] b);
    matrix_pkg::rx_byte_u u;
    u = b;
    if (u.chr >= 8'h30 && u.chr <= 8'h39) return matrix_pkg::elem_t'(u.chr - 8'h30);
    else return u.raw;
  endfunction

  task automatic check_value(input logic signed [31:0] actual,
                             input logic signed [31:0] expected, input string what);
    assert (actual === expected) else begin
      $display("** Error at %0t: %s expected %0d, got %0d", $time, what, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  // 8N1 frame sent lsb first
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      rxd = frame[i];
      repeat (BIT_CYCLES - 1) @(negedge clk);
    end
  endtask

  task automatic enter_dims(input int rows, input int cols);
    send_byte(8'h30 + rows[7:0]);
    send_byte(8'h30 + cols[7:0]);
    model_rows = rows;
    model_cols = cols;
    for (int r = 0; r < `MATRIX_MAX_ROWS; r++) begin
      for (int c = 0; c < `MATRIX_MAX_COLS; c++) model[r][c] = '0;
    end
  endtask

  task automatic send_element(input int r, input int c, input logic [7:0] b);
    send_byte(b);
    model[r][c] = decode_byte(b);
  endtask

  task automatic wait_writes(input int target);
    int cycles;
    cycles = 0;
    while (writes_seen < target && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (writes_seen < target) begin
      $display("timed out waiting for element writes, saw %0d of %0d", writes_seen, target);
      $display("*** TEST FAILED ***");
      $fatal(1, "controller stopped writing elements");
    end
  endtask

  task automatic wait_status(input logic exp_err, input logic exp_done, input string what);
    int cycles;
    cycles = 0;
    while ((err !== exp_err || input_done !== exp_done) && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (err !== exp_err || input_done !== exp_done) begin
      $display("timed out waiting for %s, err is %b and input_done is %b", what, err,
               input_done);
      $display("*** TEST FAILED ***");
      $fatal(1, "status outputs never reached the expected levels");
    end
  endtask

  task automatic check_dims();
    check_value(32'(dims_rows), model_rows, "row count");
    check_value(32'(dims_cols), model_cols, "column count");
  endtask

  // sweeps every cell since the model holds zero outside the dimensions
  task automatic check_matrix();
    check_dims();
    for (int r = 0; r < `MATRIX_MAX_ROWS; r++) begin
      for (int c = 0; c < `MATRIX_MAX_COLS; c++) begin
        @(negedge clk);
        rd_row = r[`MATRIX_ROW_IDX_W-1:0];
        rd_col = c[`MATRIX_COL_IDX_W-1:0];
        @(posedge clk);
        check_value(32'(rd_data), 32'(model[r][c]), $sformatf("element (%0d,%0d)", r, c));
      end
    end
  endtask

  initial begin
    int         base;
    logic [7:0] b;
    rst_n      = 1'b0;
    rxd        = 1'b1;
    start_en   = 1'b0;
    exit_input = 1'b0;
    rd_row     = '0;
    rd_col     = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    start_en = 1'b1;

    // 3 by 4 with digits on even elements and raw bytes on odd ones
    enter_dims(3, 4);
    base = writes_seen;
    for (int i = 0; i < 12; i++) begin
      b = random_byte();
      if (i % 2 == 0) b = 8'h30 + b % 8'd10;
      send_element(i / 4, i % 4, b);
    end
    wait_writes(base + 12);
    check_matrix();

    // reload as 1 by 1 so the old cells read zero
    enter_dims(1, 1);
    base = writes_seen;
    send_element(0, 0, random_byte());
    wait_writes(base + 1);
    check_matrix();

    // two elements then silence while the other four are padded
    enter_dims(2, 3);
    base = writes_seen;
    send_element(0, 0, random_byte());
    send_element(0, 1, 8'h37);
    wait_writes(base + 6);
    check_matrix();

    // row count 0 is rejected
    send_byte(8'h30);
    wait_status(1'b1, 1'b0, "error after row count 0");
    check_dims();
    @(negedge clk);
    start_en = 1'b0;
    wait_status(1'b0, 1'b0, "error to clear");
    @(negedge clk);
    start_en = 1'b1;
    // column count 7 is over the limit
    send_byte(8'h34);
    send_byte(8'h37);
    wait_status(1'b1, 1'b0, "error after column count 7");
    check_dims();
    @(negedge clk);
    start_en = 1'b0;
    wait_status(1'b0, 1'b0, "error to clear");

    // exit while a row count is awaited
    @(negedge clk);
    start_en   = 1'b1;
    exit_input = 1'b1;
    wait_status(1'b0, 1'b1, "done after exit");
    @(negedge clk);
    start_en   = 1'b0;
    exit_input = 1'b0;
    wait_status(1'b0, 1'b0, "done to clear");

    $display("*** TEST PASSED ***");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation timeout");
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+design
design/matrix_pkg.sv
design/uart_rx.sv
design/matrix_input.sv
design/matrix_store.sv
design/matrix_entry_top.sv
testbench/matrix_entry_properties.sv
testbench/matrix_entry_tb.sv

//--- run.sh
#!/bin/sh
# build and run the matrix entry testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module matrix_entry_tb \
  -o sim_matrix_entry
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/sim_matrix_entry
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
fi
exit $status
